// ==== rtl/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

   localparam int xlen = 32;
   localparam int mem_words = 256;
   localparam int mem_addr_bits = 8;
   localparam int reg_addr_bits = 5;

   localparam logic [6:0] op_lui = 7'b0110111;
   localparam logic [6:0] op_jal = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load = 7'b0000011;
   localparam logic [6:0] op_store = 7'b0100011;
   localparam logic [6:0] op_alu_imm = 7'b0010011;
   localparam logic [6:0] op_alu_reg = 7'b0110011;
   localparam logic [6:0] op_fence = 7'b0001111;

   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_or = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;
   localparam logic [2:0] f3_beq = 3'b000;
   localparam logic [2:0] f3_bne = 3'b001;

   // Sequencer state codes
   localparam logic [1:0] st_fetch = 2'd0;
   localparam logic [1:0] st_exec = 2'd1;
   localparam logic [1:0] st_load = 2'd2;

   // One instruction word, seen through each of the base formats
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [reg_addr_bits-1:0] rs2;
         logic [reg_addr_bits-1:0] rs1;
         logic [2:0] funct3;
         logic [reg_addr_bits-1:0] rd;
         logic [6:0] opcode;
      } r_fmt;
      struct packed {
         logic [11:0] imm_11_0;
         logic [reg_addr_bits-1:0] rs1;
         logic [2:0] funct3;
         logic [reg_addr_bits-1:0] rd;
         logic [6:0] opcode;
      } i_fmt;
      struct packed {
         logic [6:0] imm_11_5;
         logic [reg_addr_bits-1:0] rs2;
         logic [reg_addr_bits-1:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_4_0;
         logic [6:0] opcode;
      } s_fmt;
      struct packed {
         logic imm_12;
         logic [5:0] imm_10_5;
         logic [reg_addr_bits-1:0] rs2;
         logic [reg_addr_bits-1:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm_4_1;
         logic imm_11;
         logic [6:0] opcode;
      } b_fmt;
      struct packed {
         logic [19:0] imm_31_12;
         logic [reg_addr_bits-1:0] rd;
         logic [6:0] opcode;
      } u_fmt;
      struct packed {
         logic imm_20;
         logic [9:0] imm_10_1;
         logic imm_11;
         logic [7:0] imm_19_12;
         logic [reg_addr_bits-1:0] rd;
         logic [6:0] opcode;
      } j_fmt;
   } instr_t;

endpackage

`default_nettype wire

// ==== rtl/memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory
   import rv32_pkg::*;
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic                     read_enable,
   input  logic [mem_addr_bits-1:0] read_addr,
   output logic [xlen-1:0]          read_value,
   input  logic                     write_enable,
   input  logic [mem_addr_bits-1:0] write_addr,
   input  logic [xlen-1:0]          write_value,
   input  logic                     load_valid,
   input  logic [mem_addr_bits-1:0] load_addr,
   input  logic [xlen-1:0]          load_data,
   output logic                     load_ready
);

   logic [xlen-1:0] mem [mem_words];

   // The core owns the write port whenever it stores
   assign load_ready = !write_enable;

   always_ff @(posedge clock) begin
      if (write_enable) begin
         mem[write_addr] <= write_value;
      end else if (load_valid && load_ready) begin
         mem[load_addr] <= load_data;
      end
   end

   // One cycle read latency; the value holds until the next read
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         read_value <= '0;
      end else if (read_enable) begin
         read_value <= mem[read_addr];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/core_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_sequencer
   import rv32_pkg::*;
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic                     enable,
   output logic                     read_enable,
   output logic [mem_addr_bits-1:0] read_addr,
   input  logic [xlen-1:0]          read_value,
   input  logic [mem_addr_bits-1:0] load_addr_word,
   input  logic [xlen-1:0]          next_pc,
   input  logic                     retire_ready,
   input  logic                     is_load,
   input  logic                     is_fence,
   output instr_t                   instr,
   output logic                     exec_step,
   output logic                     load_phase,
   output logic [xlen-1:0]          pc,
   output logic                     halted
);

   logic [1:0] state;
   instr_t instr_q;
   logic fetch_go;

   assign exec_step = (state == st_exec);
   assign load_phase = (state == st_load);
   assign fetch_go = (state == st_fetch) && enable && !halted;

   // The fetched word is live on read_value during execute;
   // a load overwrites it, so the load phase uses the held copy
   assign instr = load_phase ? instr_q : read_value;

   assign read_enable = fetch_go || (exec_step && is_load);
   assign read_addr = exec_step ? load_addr_word : pc[mem_addr_bits+1:2];

   always_ff @(posedge clock) begin
      if (exec_step) begin
         instr_q <= read_value;
      end
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         state <= st_fetch;
         pc <= '0;
         halted <= 1'b0;
      end else if (retire_ready) begin
         pc <= next_pc;
         state <= st_fetch;
         if (is_fence) begin
            halted <= 1'b1;
         end
      end else if (fetch_go) begin
         state <= st_exec;
      end else if (exec_step && is_load) begin
         state <= st_load;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode
   import rv32_pkg::*;
(
   input  logic [6:0] opcode,
   output logic       branch_type,
   output logic       register_type_alu,
   output logic       integer_type_alu,
   output logic       integer_type_load,
   output logic       store_type,
   output logic       jump_type,
   output logic       upper_type,
   output logic       fence_type
);

   always_comb begin
      branch_type = 1'b0;
      register_type_alu = 1'b0;
      integer_type_alu = 1'b0;
      integer_type_load = 1'b0;
      store_type = 1'b0;
      jump_type = 1'b0;
      upper_type = 1'b0;
      fence_type = 1'b0;
      case (opcode)
         op_branch: begin
            branch_type = 1'b1;
         end
         op_alu_reg: begin
            register_type_alu = 1'b1;
         end
         op_alu_imm: begin
            integer_type_alu = 1'b1;
         end
         op_load: begin
            integer_type_load = 1'b1;
         end
         op_store: begin
            store_type = 1'b1;
         end
         op_jal: begin
            jump_type = 1'b1;
         end
         op_lui: begin
            upper_type = 1'b1;
         end
         op_fence: begin
            fence_type = 1'b1;
         end
         // Anything else retires as a no-op
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file
   import rv32_pkg::*;
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic [reg_addr_bits-1:0] rs1,
   input  logic [reg_addr_bits-1:0] rs2,
   output logic [xlen-1:0]          rs1_value,
   output logic [xlen-1:0]          rs2_value,
   input  logic                     rd_write_enable,
   input  logic [reg_addr_bits-1:0] rd,
   input  logic [xlen-1:0]          rd_value
);

   logic [xlen-1:0] regs [1 << reg_addr_bits];

   // x0 is cleared by reset and never written, so it always reads zero
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         for (int i = 0; i < (1 << reg_addr_bits); i++) begin
            regs[i] <= '0;
         end
      end else if (rd_write_enable && (rd != '0)) begin
         regs[rd] <= rd_value;
      end
   end

   assign rs1_value = regs[rs1];
   assign rs2_value = regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute
   import rv32_pkg::*;
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  instr_t                   instr,
   input  logic                     branch_type,
   input  logic                     register_type_alu,
   input  logic                     integer_type_alu,
   input  logic                     integer_type_load,
   input  logic                     store_type,
   input  logic                     jump_type,
   input  logic                     upper_type,
   input  logic                     exec_step,
   input  logic                     load_phase,
   input  logic [xlen-1:0]          read_value,
   output logic [reg_addr_bits-1:0] rs1,
   output logic [reg_addr_bits-1:0] rs2,
   input  logic [xlen-1:0]          rs1_value,
   input  logic [xlen-1:0]          rs2_value,
   output logic                     rd_write_enable,
   output logic [reg_addr_bits-1:0] rd,
   output logic [xlen-1:0]          rd_value,
   output logic                     mem_write_enable,
   output logic [mem_addr_bits-1:0] mem_write_addr,
   output logic [xlen-1:0]          mem_write_value,
   output logic [mem_addr_bits-1:0] load_addr_word,
   output logic [xlen-1:0]          next_pc,
   input  logic [xlen-1:0]          pc,
   output logic                     retire_ready,
   output logic                     wb_valid,
   output logic [reg_addr_bits-1:0] wb_rd,
   output logic [xlen-1:0]          wb_data
);

   logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
   logic [xlen-1:0] operand_b, alu_result, eff_addr, link_pc;
   logic alu_sub, alu_ok, equal, taken, load_pending;

   assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
   assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
   assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                   instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
   assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
   assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                   instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

   // Register indices sit at the same bits in every format
   assign rs1 = instr.r_fmt.rs1;
   assign rs2 = instr.r_fmt.rs2;
   assign rd = instr.r_fmt.rd;

   assign operand_b = register_type_alu ? rs2_value : imm_i;
   assign alu_sub = register_type_alu && instr.r_fmt.funct7[5];

   // Unsupported functions leave rd untouched
   always_comb begin
      alu_ok = 1'b1;
      case (instr.r_fmt.funct3)
         f3_add_sub: alu_result = alu_sub ? rs1_value - operand_b : rs1_value + operand_b;
         f3_xor: alu_result = rs1_value ^ operand_b;
         f3_or: alu_result = rs1_value | operand_b;
         f3_and: alu_result = rs1_value & operand_b;
         default: begin
            alu_result = '0;
            alu_ok = 1'b0;
         end
      endcase
   end

   assign eff_addr = rs1_value + (store_type ? imm_s : imm_i);
   assign load_addr_word = eff_addr[mem_addr_bits+1:2];
   assign mem_write_addr = eff_addr[mem_addr_bits+1:2];
   assign mem_write_value = rs2_value;
   assign mem_write_enable = exec_step && store_type;

   assign equal = (rs1_value == rs2_value);
   assign taken = ((instr.b_fmt.funct3 == f3_beq) && equal) ||
                  ((instr.b_fmt.funct3 == f3_bne) && !equal);
   assign link_pc = pc + 32'd4;

   always_comb begin
      next_pc = link_pc;
      if (jump_type) begin
         next_pc = pc + imm_j;
      end else if (branch_type && taken) begin
         next_pc = pc + imm_b;
      end
   end

   // Set while a load waits for its data word
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         load_pending <= 1'b0;
      end else if (exec_step && integer_type_load) begin
         load_pending <= 1'b1;
      end else if (load_phase) begin
         load_pending <= 1'b0;
      end
   end

   always_comb begin
      rd_value = alu_result;
      rd_write_enable = 1'b0;
      if (load_phase) begin
         rd_value = read_value;
         rd_write_enable = load_pending;
      end else if (exec_step) begin
         if (upper_type) begin
            rd_value = imm_u;
            rd_write_enable = 1'b1;
         end else if (jump_type) begin
            rd_value = link_pc;
            rd_write_enable = 1'b1;
         end else if (integer_type_alu || register_type_alu) begin
            rd_write_enable = alu_ok;
         end
      end
   end

   assign retire_ready = (exec_step && !integer_type_load) || load_phase;

   assign wb_valid = rd_write_enable && (rd != '0);
   assign wb_rd = rd;
   assign wb_data = rd_value;

endmodule

`default_nettype wire

// ==== rtl/rv32_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_core
   import rv32_pkg::*;
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic                     enable,
   input  logic                     load_valid,
   input  logic [mem_addr_bits-1:0] load_addr,
   input  logic [xlen-1:0]          load_data,
   output logic                     load_ready,
   output logic                     halted,
   output logic [xlen-1:0]          pc,
   output logic                     wb_valid,
   output logic [reg_addr_bits-1:0] wb_rd,
   output logic [xlen-1:0]          wb_data
);

   logic read_enable;
   logic [mem_addr_bits-1:0] read_addr;
   logic [xlen-1:0] read_value;
   logic mem_write_enable;
   logic [mem_addr_bits-1:0] mem_write_addr;
   logic [xlen-1:0] mem_write_value;

   instr_t instr;
   logic exec_step, load_phase, retire_ready;
   logic [mem_addr_bits-1:0] load_addr_word;
   logic [xlen-1:0] next_pc;

   logic branch_type, register_type_alu, integer_type_alu, integer_type_load;
   logic store_type, jump_type, upper_type, fence_type;

   logic [reg_addr_bits-1:0] rs1, rs2, rd;
   logic [xlen-1:0] rs1_value, rs2_value, rd_value;
   logic rd_write_enable;

   memory memory_0 (
      .clock(clock),
      .rst_n(rst_n),
      .read_enable(read_enable),
      .read_addr(read_addr),
      .read_value(read_value),
      .write_enable(mem_write_enable),
      .write_addr(mem_write_addr),
      .write_value(mem_write_value),
      .load_valid(load_valid),
      .load_addr(load_addr),
      .load_data(load_data),
      .load_ready(load_ready)
   );

   core_sequencer core_sequencer_0 (
      .clock(clock),
      .rst_n(rst_n),
      .enable(enable),
      .read_enable(read_enable),
      .read_addr(read_addr),
      .read_value(read_value),
      .load_addr_word(load_addr_word),
      .next_pc(next_pc),
      .retire_ready(retire_ready),
      .is_load(integer_type_load),
      .is_fence(fence_type),
      .instr(instr),
      .exec_step(exec_step),
      .load_phase(load_phase),
      .pc(pc),
      .halted(halted)
   );

   decode decode_0 (
      .opcode(instr.r_fmt.opcode),
      .branch_type(branch_type),
      .register_type_alu(register_type_alu),
      .integer_type_alu(integer_type_alu),
      .integer_type_load(integer_type_load),
      .store_type(store_type),
      .jump_type(jump_type),
      .upper_type(upper_type),
      .fence_type(fence_type)
   );

   execute execute_0 (
      .clock(clock),
      .rst_n(rst_n),
      .instr(instr),
      .branch_type(branch_type),
      .register_type_alu(register_type_alu),
      .integer_type_alu(integer_type_alu),
      .integer_type_load(integer_type_load),
      .store_type(store_type),
      .jump_type(jump_type),
      .upper_type(upper_type),
      .exec_step(exec_step),
      .load_phase(load_phase),
      .read_value(read_value),
      .rs1(rs1),
      .rs2(rs2),
      .rs1_value(rs1_value),
      .rs2_value(rs2_value),
      .rd_write_enable(rd_write_enable),
      .rd(rd),
      .rd_value(rd_value),
      .mem_write_enable(mem_write_enable),
      .mem_write_addr(mem_write_addr),
      .mem_write_value(mem_write_value),
      .load_addr_word(load_addr_word),
      .next_pc(next_pc),
      .pc(pc),
      .retire_ready(retire_ready),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .wb_data(wb_data)
   );

   register_file register_file_0 (
      .clock(clock),
      .rst_n(rst_n),
      .rs1(rs1),
      .rs2(rs2),
      .rs1_value(rs1_value),
      .rs2_value(rs2_value),
      .rd_write_enable(rd_write_enable),
      .rd(rd),
      .rd_value(rd_value)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_rv32.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv32
   import rv32_pkg::*;
();

   logic clock;
   logic rst_n;
   logic enable;
   logic load_valid;
   logic load_ready;
   logic [mem_addr_bits-1:0] load_addr;
   logic [xlen-1:0] load_data;
   logic halted;
   logic [xlen-1:0] pc;
   logic wb_valid;
   logic [reg_addr_bits-1:0] wb_rd;
   logic [xlen-1:0] wb_data;

   int timeout_cycles = 200;

   logic [xlen-1:0] program_words [$];
   logic [reg_addr_bits-1:0] exp_rd [$];
   logic [xlen-1:0] exp_data [$];
   logic [reg_addr_bits-1:0] got_rd [$];
   logic [xlen-1:0] got_data [$];
   logic [xlen-1:0] model_regs [32];

   rv32_core dut_i (
      .clock(clock),
      .rst_n(rst_n),
      .enable(enable),
      .load_valid(load_valid),
      .load_addr(load_addr),
      .load_data(load_data),
      .load_ready(load_ready),
      .halted(halted),
      .pc(pc),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .wb_data(wb_data)
   );

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("ERROR at time %0t: %s expected 0x%h, actual 0x%h",
                                  $time, name, expected, actual));
      end
   endtask

   task automatic compare_reg_index(input string name,
                                    input logic [reg_addr_bits-1:0] expected,
                                    input logic [reg_addr_bits-1:0] actual);
      if (actual !== expected) begin
         report_failure($sformatf("ERROR at time %0t: %s expected x%0d, actual x%0d",
                                  $time, name, expected, actual));
      end
   endtask

   task automatic compare_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         report_failure($sformatf("ERROR at time %0t: %s expected %b, actual %b",
                                  $time, name, expected, actual));
      end
   endtask

   // Instruction encoders, built through the format views of the union
   function automatic instr_t alu_reg_instr(input logic [6:0] funct7,
                                            input logic [2:0] funct3,
                                            input logic [reg_addr_bits-1:0] rd,
                                            input logic [reg_addr_bits-1:0] rs1,
                                            input logic [reg_addr_bits-1:0] rs2);
      instr_t word;
      word.r_fmt.funct7 = funct7;
      word.r_fmt.rs2 = rs2;
      word.r_fmt.rs1 = rs1;
      word.r_fmt.funct3 = funct3;
      word.r_fmt.rd = rd;
      word.r_fmt.opcode = op_alu_reg;
      return word;
   endfunction

   function automatic instr_t imm_instr(input logic [6:0] opcode, input logic [2:0] funct3,
                                        input logic [reg_addr_bits-1:0] rd,
                                        input logic [reg_addr_bits-1:0] rs1,
                                        input logic [11:0] imm);
      instr_t word;
      word.i_fmt.imm_11_0 = imm;
      word.i_fmt.rs1 = rs1;
      word.i_fmt.funct3 = funct3;
      word.i_fmt.rd = rd;
      word.i_fmt.opcode = opcode;
      return word;
   endfunction

   function automatic instr_t store_word_instr(input logic [reg_addr_bits-1:0] rs2,
                                               input logic [reg_addr_bits-1:0] rs1,
                                               input logic [11:0] imm);
      instr_t word;
      word.s_fmt.imm_11_5 = imm[11:5];
      word.s_fmt.rs2 = rs2;
      word.s_fmt.rs1 = rs1;
      word.s_fmt.funct3 = 3'b010;
      word.s_fmt.imm_4_0 = imm[4:0];
      word.s_fmt.opcode = op_store;
      return word;
   endfunction

   function automatic instr_t branch_instr(input logic [2:0] funct3,
                                           input logic [reg_addr_bits-1:0] rs1,
                                           input logic [reg_addr_bits-1:0] rs2,
                                           input logic [12:0] offset);
      instr_t word;
      word.b_fmt.imm_12 = offset[12];
      word.b_fmt.imm_10_5 = offset[10:5];
      word.b_fmt.rs2 = rs2;
      word.b_fmt.rs1 = rs1;
      word.b_fmt.funct3 = funct3;
      word.b_fmt.imm_4_1 = offset[4:1];
      word.b_fmt.imm_11 = offset[11];
      word.b_fmt.opcode = op_branch;
      return word;
   endfunction

   function automatic instr_t jal_instr(input logic [reg_addr_bits-1:0] rd,
                                        input logic [20:0] offset);
      instr_t word;
      word.j_fmt.imm_20 = offset[20];
      word.j_fmt.imm_10_1 = offset[10:1];
      word.j_fmt.imm_11 = offset[11];
      word.j_fmt.imm_19_12 = offset[19:12];
      word.j_fmt.rd = rd;
      word.j_fmt.opcode = op_jal;
      return word;
   endfunction

   function automatic instr_t lui_instr(input logic [reg_addr_bits-1:0] rd,
                                        input logic [19:0] upper);
      instr_t word;
      word.u_fmt.imm_31_12 = upper;
      word.u_fmt.rd = rd;
      word.u_fmt.opcode = op_lui;
      return word;
   endfunction

   function automatic logic [xlen-1:0] sign_extend12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   function automatic logic [xlen-1:0] current_address();
      return xlen'(program_words.size() * 4);
   endfunction

   task automatic clear_program();
      program_words.delete();
      exp_rd.delete();
      exp_data.delete();
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
   endtask

   task automatic place(input instr_t word);
      program_words.push_back(word);
   endtask

   // Reference register update; x0 writes are dropped and leave no event
   task automatic note_write(input logic [reg_addr_bits-1:0] rd, input logic [xlen-1:0] value);
      if (rd != '0) begin
         model_regs[rd] = value;
         exp_rd.push_back(rd);
         exp_data.push_back(value);
      end
   endtask

   task automatic place_addi(input logic [reg_addr_bits-1:0] rd,
                             input logic [reg_addr_bits-1:0] rs1, input logic [11:0] imm);
      place(imm_instr(op_alu_imm, f3_add_sub, rd, rs1, imm));
      note_write(rd, model_regs[rs1] + sign_extend12(imm));
   endtask

   task automatic host_write(input logic [mem_addr_bits-1:0] addr, input logic [xlen-1:0] data);
      int waited;
      logic accepted;
      waited = 0;
      accepted = 1'b0;
      load_valid = 1'b1;
      load_addr = addr;
      load_data = data;
      while (!accepted) begin
         @(negedge clock);
         if (load_ready === 1'b1) begin
            accepted = 1'b1;
         end else begin
            waited++;
            if (waited > timeout_cycles) begin
               report_failure("Host load was never accepted by the memory");
            end
         end
      end
      @(posedge clock);
      #1;
      load_valid = 1'b0;
   endtask

   task automatic load_program();
      foreach (program_words[i]) begin
         host_write(mem_addr_bits'(i), program_words[i]);
      end
   endtask

   task automatic reset_core();
      rst_n = 1'b0;
      repeat (3) @(posedge clock);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic run_to_halt();
      int cycles;
      logic seen_halt;
      cycles = 0;
      seen_halt = 1'b0;
      got_rd.delete();
      got_data.delete();
      enable = 1'b1;
      while (!seen_halt) begin
         @(negedge clock);
         if (wb_valid === 1'b1) begin
            got_rd.push_back(wb_rd);
            got_data.push_back(wb_data);
         end
         if (halted === 1'b1) begin
            seen_halt = 1'b1;
         end else begin
            cycles++;
            if (cycles > timeout_cycles) begin
               report_failure("Core did not halt within the cycle limit");
            end
         end
      end
      @(posedge clock);
      #1;
   endtask

   task automatic check_writebacks();
      if (got_rd.size() != exp_rd.size()) begin
         report_failure($sformatf("Wrong number of write-back events: expected %0d, saw %0d",
                                  exp_rd.size(), got_rd.size()));
      end
      foreach (exp_rd[i]) begin
         compare_reg_index("wb_rd", exp_rd[i], got_rd[i]);
         compare_word("wb_data", exp_data[i], got_data[i]);
      end
   endtask

   task automatic execute_program();
      load_program();
      reset_core();
      run_to_halt();
      check_writebacks();
      enable = 1'b0;
   endtask

   task automatic idle_after_reset();
      @(negedge clock);
      compare_word("pc", '0, pc);
      compare_flag("halted", 1'b0, halted);
      compare_flag("wb_valid", 1'b0, wb_valid);
      compare_flag("load_ready", 1'b1, load_ready);
      repeat (5) begin
         @(negedge clock);
         compare_word("pc", '0, pc);
      end
      @(posedge clock);
      #1;
   endtask

   task automatic alu_program();
      logic [11:0] imm_a, imm_b, imm_c;
      imm_a = 12'($urandom());
      imm_b = 12'($urandom());
      imm_c = 12'($urandom());
      clear_program();
      place_addi(5'd1, 5'd0, imm_a);
      place_addi(5'd2, 5'd0, imm_b);
      place_addi(5'd3, 5'd1, imm_c);
      place(alu_reg_instr(7'h00, f3_add_sub, 5'd4, 5'd1, 5'd2));
      note_write(5'd4, model_regs[1] + model_regs[2]);
      place(alu_reg_instr(7'h20, f3_add_sub, 5'd5, 5'd3, 5'd2));
      note_write(5'd5, model_regs[3] - model_regs[2]);
      place(alu_reg_instr(7'h00, f3_and, 5'd6, 5'd1, 5'd3));
      note_write(5'd6, model_regs[1] & model_regs[3]);
      place(alu_reg_instr(7'h00, f3_or, 5'd7, 5'd2, 5'd3));
      note_write(5'd7, model_regs[2] | model_regs[3]);
      place(alu_reg_instr(7'h00, f3_xor, 5'd8, 5'd4, 5'd5));
      note_write(5'd8, model_regs[4] ^ model_regs[5]);
      // Neither write to x0 may show up on the write-back port
      place_addi(5'd0, 5'd1, imm_c);
      place(alu_reg_instr(7'h00, f3_add_sub, 5'd0, 5'd1, 5'd2));
      place(imm_instr(op_fence, 3'b000, 5'd0, 5'd0, 12'h000));
      execute_program();
   endtask

   task automatic memory_round_trip();
      logic [19:0] upper;
      logic [11:0] lower;
      upper = 20'($urandom());
      lower = 12'($urandom());
      clear_program();
      place(lui_instr(5'd10, upper));
      note_write(5'd10, {upper, 12'h000});
      place_addi(5'd10, 5'd10, lower);
      place_addi(5'd11, 5'd0, 12'h100);
      place(store_word_instr(5'd10, 5'd11, 12'd20));
      place(imm_instr(op_load, 3'b010, 5'd12, 5'd11, 12'd20));
      note_write(5'd12, model_regs[10]);
      // Same word reached from another base with a zero offset
      place_addi(5'd14, 5'd0, 12'h114);
      place(imm_instr(op_load, 3'b010, 5'd15, 5'd14, 12'd0));
      note_write(5'd15, model_regs[10]);
      place(imm_instr(op_fence, 3'b000, 5'd0, 5'd0, 12'h000));
      execute_program();
   endtask

   task automatic branch_and_jump();
      logic [xlen-1:0] link;
      clear_program();
      place_addi(5'd1, 5'd0, 12'd7);
      place_addi(5'd2, 5'd0, 12'd7);
      place(branch_instr(f3_beq, 5'd1, 5'd2, 13'd8));
      place(imm_instr(op_alu_imm, f3_add_sub, 5'd3, 5'd0, 12'd1));
      place(branch_instr(f3_bne, 5'd1, 5'd2, 13'd8));
      place_addi(5'd4, 5'd0, 12'd2);
      link = current_address() + 32'd4;
      place(jal_instr(5'd5, 21'd8));
      note_write(5'd5, link);
      place(imm_instr(op_alu_imm, f3_add_sub, 5'd6, 5'd0, 12'd3));
      place_addi(5'd7, 5'd5, 12'd0);
      place(imm_instr(op_fence, 3'b000, 5'd0, 5'd0, 12'h000));
      execute_program();
   endtask

   task automatic fence_halts_core();
      logic [xlen-1:0] fence_addr;
      clear_program();
      place_addi(5'd1, 5'd0, 12'd9);
      fence_addr = current_address();
      place(imm_instr(op_fence, 3'b000, 5'd0, 5'd0, 12'h000));
      place(imm_instr(op_alu_imm, f3_add_sub, 5'd2, 5'd0, 12'd4));
      place(imm_instr(op_alu_imm, f3_add_sub, 5'd3, 5'd0, 12'd5));
      load_program();
      reset_core();
      run_to_halt();
      // Enable stays high here; the halted core must not fetch again
      repeat (10) begin
         @(negedge clock);
         compare_flag("wb_valid", 1'b0, wb_valid);
         compare_flag("halted", 1'b1, halted);
         compare_word("pc", fence_addr + 32'd4, pc);
      end
      @(posedge clock);
      #1;
      check_writebacks();
      enable = 1'b0;
   endtask

   task automatic reload_while_halted();
      clear_program();
      compare_flag("halted", 1'b1, halted);
      place(lui_instr(5'd20, 20'($urandom())));
      note_write(5'd20, {program_words[0][31:12], 12'h000});
      place_addi(5'd21, 5'd20, 12'h7ff);
      place(imm_instr(op_fence, 3'b000, 5'd0, 5'd0, 12'h000));
      load_program();
      reset_core();
      @(negedge clock);
      compare_word("pc", '0, pc);
      compare_flag("halted", 1'b0, halted);
      @(posedge clock);
      #1;
      run_to_halt();
      check_writebacks();
      enable = 1'b0;
   endtask

   initial begin
      void'($urandom(80689));
      rst_n = 1'b0;
      enable = 1'b0;
      load_valid = 1'b0;
      load_addr = '0;
      load_data = '0;
      repeat (3) @(posedge clock);
      #1;
      rst_n = 1'b1;
      idle_after_reset();
      alu_program();
      memory_round_trip();
      branch_and_jump();
      fence_halts_core();
      reload_while_halted();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/rv32_pkg.sv
rtl/memory.sv
rtl/core_sequencer.sv
rtl/decode.sv
rtl/register_file.sv
rtl/execute.sv
rtl/rv32_core.sv
testbench/tb_rv32.sv

// ==== Bender.yml ====
package:
  name: rv32_core

sources:
  - rtl/rv32_pkg.sv
  - rtl/memory.sv
  - rtl/core_sequencer.sv
  - rtl/decode.sv
  - rtl/register_file.sv
  - rtl/execute.sv
  - rtl/rv32_core.sv
  - target: simulation
    files:
      - testbench/tb_rv32.sv
